//--- common/tlk_tx_cfg.svh
// constants of the TLK2711 transmit path
// 8b/10b control codes, frame header words, run lengths and register map
// include in every file that needs one of these values

`ifndef TLK_TX_CFG_SVH
`define TLK_TX_CFG_SVH

// sync pair and frame delimiters
`define TLK_K28_5 8'hBC
`define TLK_D5_6  8'hC5
`define TLK_K27_7 8'hFB
`define TLK_K28_2 8'h5C
`define TLK_K30_7 8'hFE
`define TLK_K29_7 8'hFD

// header and file sign words
`define TLK_HEAD_0   16'hEB90
`define TLK_HEAD_1   16'hE116
`define TLK_TX_IND   8'h81
`define TLK_FILE_END 8'h01

// sync runs, the gap is cut down from 257 for simulation
`define TLK_SYNC_WORDS 6
`define TLK_GAP_WORDS  16
`define TLK_FIFO_WORDS 512

// APB register map
`define TLK_REG_CTRL       8'h00
`define TLK_REG_BODY_LEN   8'h04
`define TLK_REG_TAIL_LEN   8'h08
`define TLK_REG_BODY_NUM   8'h0C
`define TLK_REG_INTR_WIDTH 8'h10
`define TLK_REG_STATUS     8'h14

`endif

//--- common/tlk_tx_pkg.sv
// shared types for the TLK2711 transmit path
// holds the vector typedefs that carry a meaning and the framer state enum
// modules import it inside their bodies and use scoped names on their ports

package tlk_tx_pkg;

    // one link character pair, msb character in [15:8]
    typedef logic [15:0] word_t;

    // one DMA beat, four link words
    typedef logic [63:0] beat_t;

    // frame length in bytes
    typedef logic [15:0] len_t;

    // frame index within one transfer
    typedef logic [23:0] frame_num_t;

    // interrupt width in clocks
    typedef logic [15:0] intr_width_t;

    // FIFO fill in words, 0 to 512
    typedef logic [9:0] fifo_level_t;

    // APB address and data
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // framer states, the code shows up in STATUS bits 3:0
    typedef enum logic [3:0] {
        tx_idle, tx_sync, tx_sof, tx_head0, tx_head1,
        tx_file_sign, tx_frame_num, tx_vld_len, tx_vld_data,
        tx_checksum, tx_eof, tx_gap, tx_interrupt
    } tx_state_e;

endpackage

//--- tx_framer/tlk_tx_fifo.sv
// width-narrowing FIFO between the DMA and the framer
// takes 64-bit beats and hands out 16-bit words, lowest word first
// first-word fall-through, o_rd_data is valid whenever o_empty is low
// o_level counts words and lets the framer hold a frame until its payload is in

`timescale 1ns/1ps
`include "tlk_tx_cfg.svh"

module tlk_tx_fifo (
    input  logic                      clk,
    input  logic                      i_soft_reset,
    input  logic                      i_dma_valid,
    input  tlk_tx_pkg::beat_t         i_dma_data,
    output logic                      o_dma_ready,
    input  logic                      i_rd_en,
    output tlk_tx_pkg::word_t         o_rd_data,
    output tlk_tx_pkg::fifo_level_t   o_level,
    output logic                      o_empty,
    output logic                      o_full
);
    import tlk_tx_pkg::*;

    localparam int WORD_AW = $clog2(`TLK_FIFO_WORDS);
    localparam int BEATS   = `TLK_FIFO_WORDS / 4;

    // storage is kept in beats, words are picked out on the read side
    beat_t mem [BEATS];

    logic [WORD_AW-3:0] wr_ptr;
    logic [WORD_AW-1:0] rd_ptr;
    beat_t              rd_beat;
    logic               wr_en;
    logic               rd_en;

    // ready needs room for a whole beat
    assign o_dma_ready = (o_level <= fifo_level_t'(`TLK_FIFO_WORDS - 4));
    assign o_empty     = (o_level == '0);
    assign o_full      = (o_level == fifo_level_t'(`TLK_FIFO_WORDS));

    assign wr_en = i_dma_valid & o_dma_ready;
    assign rd_en = i_rd_en & ~o_empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_dma_data;
        end
    end

    assign rd_beat   = mem[rd_ptr[WORD_AW-1:2]];
    assign o_rd_data = rd_beat[rd_ptr[1:0]*16 +: 16];

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_level <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_level <= o_level + (wr_en ? 10'd4 : 10'd0) - (rd_en ? 10'd1 : 10'd0);
        end
    end

endmodule

//--- tx_framer/tlk_tx_framer.sv
// frame state machine of the TLK2711 transmit path
// sends sync words, then body_num+1 frames, then holds the interrupt
// the character for state S leaves the output register one clock after S
// a frame starts only once the FIFO holds all its payload words

`timescale 1ns/1ps
`include "tlk_tx_cfg.svh"

module tlk_tx_framer (
    input  logic                      clk,
    input  logic                      i_soft_reset,
    input  logic                      i_start,
    input  tlk_tx_pkg::len_t          i_body_len,
    input  tlk_tx_pkg::len_t          i_tail_len,
    input  tlk_tx_pkg::frame_num_t    i_body_num,
    input  tlk_tx_pkg::intr_width_t   i_intr_width,
    input  tlk_tx_pkg::fifo_level_t   i_fifo_level,
    input  tlk_tx_pkg::word_t         i_fifo_data,
    output logic                      o_fifo_rd,
    output tlk_tx_pkg::tx_state_e     o_state,
    output tlk_tx_pkg::word_t         o_txd,
    output logic                      o_tkmsb,
    output logic                      o_tklsb,
    output logic                      o_enable,
    output logic                      o_lckrefn,
    output logic                      o_tx_interrupt
);
    import tlk_tx_pkg::*;

    tx_state_e  state, state_nx;
    len_t       cnt;
    frame_num_t frame_cnt;
    logic       last_sent;
    word_t      csum;
    len_t       cur_len;
    len_t       need_words;
    logic       is_last;
    logic       level_ok;
    word_t      txd_d;
    logic       tkmsb_d;
    logic       tklsb_d;

    // length and start rule of the frame at frame_cnt
    assign is_last    = (frame_cnt == i_body_num);
    assign cur_len    = is_last ? i_tail_len : i_body_len;
    assign need_words = {1'b0, cur_len[15:1]};
    assign level_ok   = ({6'd0, i_fifo_level} >= need_words);
    assign o_fifo_rd  = (state == tx_vld_data);
    assign o_state    = state;

    always_comb begin
        state_nx = state;
        case (state)
            tx_idle:      if (i_start) state_nx = tx_sync;
            tx_sync: begin
                if (cnt >= len_t'(`TLK_SYNC_WORDS - 1) && level_ok) state_nx = tx_sof;
            end
            tx_sof:       state_nx = tx_head0;
            tx_head0:     state_nx = tx_head1;
            tx_head1:     state_nx = tx_file_sign;
            tx_file_sign: state_nx = tx_frame_num;
            tx_frame_num: state_nx = tx_vld_len;
            tx_vld_len:   state_nx = (need_words == '0) ? tx_checksum : tx_vld_data;
            tx_vld_data:  if (cnt == need_words - 16'd1) state_nx = tx_checksum;
            tx_checksum:  state_nx = tx_eof;
            tx_eof:       state_nx = tx_gap;
            tx_gap: begin
                if (cnt >= len_t'(`TLK_GAP_WORDS - 1)) begin
                    if (last_sent) state_nx = tx_interrupt;
                    else if (level_ok) state_nx = tx_sof;
                end
            end
            tx_interrupt: if ((cnt + 16'd1) >= i_intr_width) state_nx = tx_idle;
            default:      state_nx = tx_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // state, counters and checksum
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state     <= tx_idle;
            cnt       <= '0;
            frame_cnt <= '0;
            last_sent <= 1'b0;
            csum      <= '0;
        end else begin
            state <= state_nx;
            // one counter for sync, gap, payload and interrupt runs
            if (state_nx != state) cnt <= '0;
            else if (cnt != '1) cnt <= cnt + 16'd1;
            if (state == tx_idle) begin
                frame_cnt <= '0;
                last_sent <= 1'b0;
            end else if (state == tx_eof) begin
                frame_cnt <= frame_cnt + 24'd1;
                last_sent <= is_last;
            end
            if (state == tx_sof) csum <= '0;
            else if (state inside {tx_frame_num, tx_vld_len, tx_vld_data}) csum <= csum + txd_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // character select and output register
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        tkmsb_d = 1'b0;
        tklsb_d = 1'b0;
        case (state)
            tx_sof: begin
                txd_d   = {`TLK_K28_2, `TLK_K27_7};
                tkmsb_d = 1'b1;
                tklsb_d = 1'b1;
            end
            tx_head0:     txd_d = `TLK_HEAD_0;
            tx_head1:     txd_d = `TLK_HEAD_1;
            tx_file_sign: txd_d = {`TLK_TX_IND, is_last ? `TLK_FILE_END : 8'h00};
            tx_frame_num: txd_d = frame_cnt[15:0];
            tx_vld_len:   txd_d = cur_len;
            tx_vld_data:  txd_d = i_fifo_data;
            tx_checksum:  txd_d = csum;
            tx_eof: begin
                txd_d   = {`TLK_K29_7, `TLK_K30_7};
                tkmsb_d = 1'b1;
                tklsb_d = 1'b1;
            end
            // idle, sync, gap and interrupt all send the sync pair
            default: begin
                txd_d   = {`TLK_D5_6, `TLK_K28_5};
                tklsb_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_txd          <= {`TLK_D5_6, `TLK_K28_5};
            o_tkmsb        <= 1'b0;
            o_tklsb        <= 1'b1;
            o_enable       <= 1'b0;
            o_lckrefn      <= 1'b0;
            o_tx_interrupt <= 1'b0;
        end else begin
            o_txd          <= txd_d;
            o_tkmsb        <= tkmsb_d;
            o_tklsb        <= tklsb_d;
            o_enable       <= 1'b1;
            o_lckrefn      <= 1'b1;
            o_tx_interrupt <= (state == tx_interrupt);
        end
    end

endmodule

//--- source/tlk_tx_regs.sv
// APB configuration registers of the TLK2711 transmit path
// no wait states, pready is tied high
// CTRL bit 0 writes a one-cycle start pulse, bits 1 and 2 hold loopback and pre
// STATUS is read only and built from the live framer state and FIFO flags

`timescale 1ns/1ps
`include "tlk_tx_cfg.svh"

module tlk_tx_regs (
    input  logic                      clk,
    input  logic                      i_soft_reset,
    input  logic                      i_psel,
    input  logic                      i_penable,
    input  logic                      i_pwrite,
    input  tlk_tx_pkg::apb_addr_t     i_paddr,
    input  tlk_tx_pkg::apb_data_t     i_pwdata,
    output tlk_tx_pkg::apb_data_t     o_prdata,
    output logic                      o_pready,
    output logic                      o_pslverr,
    output logic                      o_start,
    output logic                      o_loopen,
    output logic                      o_pre,
    output tlk_tx_pkg::len_t          o_body_len,
    output tlk_tx_pkg::len_t          o_tail_len,
    output tlk_tx_pkg::frame_num_t    o_body_num,
    output tlk_tx_pkg::intr_width_t   o_intr_width,
    input  tlk_tx_pkg::tx_state_e     i_state,
    input  logic                      i_fifo_empty,
    input  logic                      i_fifo_full
);
    import tlk_tx_pkg::*;

    logic access;
    logic addr_hit;
    logic wr_en;
    logic busy;

    assign access = i_psel & i_penable;
    assign busy   = (i_state != tx_idle);

    always_comb begin
        case (i_paddr)
            `TLK_REG_CTRL, `TLK_REG_BODY_LEN, `TLK_REG_TAIL_LEN,
            `TLK_REG_BODY_NUM, `TLK_REG_INTR_WIDTH, `TLK_REG_STATUS: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    // STATUS is read only
    assign o_pslverr = access & (~addr_hit | (i_pwrite & (i_paddr == `TLK_REG_STATUS)));
    assign o_pready  = 1'b1;
    assign wr_en     = access & i_pwrite & ~o_pslverr;

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_start      <= 1'b0;
            o_loopen     <= 1'b0;
            o_pre        <= 1'b0;
            o_body_len   <= '0;
            o_tail_len   <= '0;
            o_body_num   <= '0;
            o_intr_width <= '0;
        end else begin
            o_start <= 1'b0;
            if (wr_en) begin
                case (i_paddr)
                    `TLK_REG_CTRL: begin
                        o_start  <= i_pwdata[0];
                        o_loopen <= i_pwdata[1];
                        o_pre    <= i_pwdata[2];
                    end
                    `TLK_REG_BODY_LEN:   o_body_len   <= i_pwdata[15:0];
                    `TLK_REG_TAIL_LEN:   o_tail_len   <= i_pwdata[15:0];
                    `TLK_REG_BODY_NUM:   o_body_num   <= i_pwdata[23:0];
                    `TLK_REG_INTR_WIDTH: o_intr_width <= i_pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    // read mux, start bit does not hold so it reads as zero
    always_comb begin
        case (i_paddr)
            `TLK_REG_CTRL:       o_prdata = {29'd0, o_pre, o_loopen, 1'b0};
            `TLK_REG_BODY_LEN:   o_prdata = {16'd0, o_body_len};
            `TLK_REG_TAIL_LEN:   o_prdata = {16'd0, o_tail_len};
            `TLK_REG_BODY_NUM:   o_prdata = {8'd0, o_body_num};
            `TLK_REG_INTR_WIDTH: o_prdata = {16'd0, o_intr_width};
            `TLK_REG_STATUS:     o_prdata = {25'd0, busy, i_fifo_full, i_fifo_empty, i_state};
            default:             o_prdata = '0;
        endcase
    end

endmodule

//--- source/tlk_tx_top.sv
// top level of the TLK2711 transmit path
// APB registers steer the framer, DMA beats reach it through the FIFO
// link pins go straight to the TLK2711 transmit interface

`timescale 1ns/1ps

module tlk_tx_top (
    input  logic                    clk,
    input  logic                    i_soft_reset,
    // APB configuration port
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  tlk_tx_pkg::apb_addr_t   i_paddr,
    input  tlk_tx_pkg::apb_data_t   i_pwdata,
    output tlk_tx_pkg::apb_data_t   o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    // DMA stream
    input  logic                    i_dma_valid,
    input  tlk_tx_pkg::beat_t       i_dma_data,
    output logic                    o_dma_ready,
    // TLK2711 pins
    output tlk_tx_pkg::word_t       o_txd,
    output logic                    o_tkmsb,
    output logic                    o_tklsb,
    output logic                    o_enable,
    output logic                    o_lckrefn,
    output logic                    o_loopen,
    output logic                    o_pre,
    output logic                    o_tx_interrupt
);
    import tlk_tx_pkg::*;

    logic        start;
    len_t        body_len;
    len_t        tail_len;
    frame_num_t  body_num;
    intr_width_t intr_width;
    tx_state_e   state;
    logic        fifo_empty;
    logic        fifo_full;
    logic        fifo_rd;
    word_t       fifo_data;
    fifo_level_t fifo_level;

    tlk_tx_regs regs0 (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_start      (start),
        .o_loopen     (o_loopen),
        .o_pre        (o_pre),
        .o_body_len   (body_len),
        .o_tail_len   (tail_len),
        .o_body_num   (body_num),
        .o_intr_width (intr_width),
        .i_state      (state),
        .i_fifo_empty (fifo_empty),
        .i_fifo_full  (fifo_full)
    );

    tlk_tx_fifo fifo0 (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_dma_valid  (i_dma_valid),
        .i_dma_data   (i_dma_data),
        .o_dma_ready  (o_dma_ready),
        .i_rd_en      (fifo_rd),
        .o_rd_data    (fifo_data),
        .o_level      (fifo_level),
        .o_empty      (fifo_empty),
        .o_full       (fifo_full)
    );

    tlk_tx_framer framer0 (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_start        (start),
        .i_body_len     (body_len),
        .i_tail_len     (tail_len),
        .i_body_num     (body_num),
        .i_intr_width   (intr_width),
        .i_fifo_level   (fifo_level),
        .i_fifo_data    (fifo_data),
        .o_fifo_rd      (fifo_rd),
        .o_state        (state),
        .o_txd          (o_txd),
        .o_tkmsb        (o_tkmsb),
        .o_tklsb        (o_tklsb),
        .o_enable       (o_enable),
        .o_lckrefn      (o_lckrefn),
        .o_tx_interrupt (o_tx_interrupt)
    );

endmodule

//--- tests/tb_tlk_tx.sv
// self-checking testbench for the TLK2711 transmit path
// reads one test per line from tests/tlk_tx_vectors.txt, sets up the DUT over APB,
// feeds random DMA beats and checks every link character against a model of the frame rules
// run from the project root, see run.sh

`timescale 1ns/1ps
`include "tlk_tx_cfg.svh"

module tb_tlk_tx;
    import tlk_tx_pkg::*;

    localparam word_t SYNC_WORD = {`TLK_D5_6, `TLK_K28_5};
    localparam word_t SOF_WORD  = {`TLK_K28_2, `TLK_K27_7};
    localparam word_t EOF_WORD  = {`TLK_K29_7, `TLK_K30_7};
    localparam int    MAX_TESTS = 32;

    logic        clk;
    logic        i_soft_reset;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    apb_addr_t   i_paddr;
    apb_data_t   i_pwdata;
    apb_data_t   o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        i_dma_valid;
    beat_t       i_dma_data;
    logic        o_dma_ready;
    word_t       o_txd;
    logic        o_tkmsb;
    logic        o_tklsb;
    logic        o_enable;
    logic        o_lckrefn;
    logic        o_loopen;
    logic        o_pre;
    logic        o_tx_interrupt;

    integer      seed = 57;
    logic        dma_on;
    longint      limit_ns;

    // payload model, a ring of words in DMA order
    word_t       model_q [1024];
    logic [9:0]  q_wr;
    logic [9:0]  q_rd;

    int          n_tests;
    int          t_body [MAX_TESTS];
    int          t_tail [MAX_TESTS];
    int          t_num  [MAX_TESTS];
    int          t_intr [MAX_TESTS];
    int          t_rst  [MAX_TESTS];

    always #20 clk = ~clk;

    tlk_tx_top dut0 (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr),
        .i_dma_valid    (i_dma_valid),
        .i_dma_data     (i_dma_data),
        .o_dma_ready    (o_dma_ready),
        .o_txd          (o_txd),
        .o_tkmsb        (o_tkmsb),
        .o_tklsb        (o_tklsb),
        .o_enable       (o_enable),
        .o_lckrefn      (o_lckrefn),
        .o_loopen       (o_loopen),
        .o_pre          (o_pre),
        .o_tx_interrupt (o_tx_interrupt)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    task abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task check_flags(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s K-flags are %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task check_data(input apb_data_t got, input apb_data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task check_char(input word_t d, input logic [1:0] k, input word_t exp_d,
                    input logic [1:0] exp_k, input string what);
        check_word(d, exp_d, what);
        check_flags(k, exp_k, what);
    endtask

    task check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB master and link sampling
    ////////////////////////////////////////////////////////////////////////////
    task apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                    output apb_data_t rdata, output logic err);
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge clk);
        i_penable <= 1'b1;
        // access phase, sampled mid-cycle
        @(negedge clk);
        rdata = o_prdata;
        err   = o_pslverr;
        check_bit(o_pready, 1'b1, "pready");
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
    endtask

    task apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rd;
        logic      err;
        apb_access(addr, 1'b1, wdata, rd, err);
        check_bit(err, 1'b0, "pslverr on write");
    endtask

    task apb_read_check(input apb_addr_t addr, input apb_data_t exp, input string what);
        apb_data_t rd;
        logic      err;
        apb_access(addr, 1'b0, '0, rd, err);
        check_bit(err, 1'b0, "pslverr on read");
        check_data(rd, exp, what);
    endtask

    task sample_link(output word_t d, output logic [1:0] k);
        @(negedge clk);
        d = o_txd;
        k = {o_tkmsb, o_tklsb};
    endtask

    // sync words only, interrupt low, link enabled
    // no reads while idle, so the model count is the FIFO fill
    task check_idle(input int cycles);
        word_t      d;
        logic [1:0] k;
        logic [9:0] used;
        int         room;
        for (int i = 0; i < cycles; i++) begin
            sample_link(d, k);
            used = q_wr - q_rd;
            room = `TLK_FIFO_WORDS - int'(used);
            check_char(d, k, SYNC_WORD, 2'b01, "idle character");
            check_bit(o_tx_interrupt, 1'b0, "interrupt while idle");
            check_bit(o_enable, 1'b1, "enable");
            check_bit(o_lckrefn, 1'b1, "lckrefn");
            check_bit(o_dma_ready, room >= 4, "dma ready");
        end
    endtask

    task wait_for_sof(input int min_sync);
        word_t      d;
        logic [1:0] k;
        int         n;
        n = 0;
        sample_link(d, k);
        while (!(k == 2'b11 && d == SOF_WORD)) begin
            check_char(d, k, SYNC_WORD, 2'b01, "sync before frame");
            check_bit(o_tx_interrupt, 1'b0, "interrupt before frame");
            n++;
            sample_link(d, k);
        end
        if (n < min_sync) begin
            abort_run($sformatf("FAILED at %0d ns: sync run of %0d words, expected at least %0d",
                                $time, n, min_sync));
        end
    endtask

    // everything after sof, checksum is a 16-bit wrapping sum
    task check_frame(input int idx, input int len, input logic last);
        word_t      d;
        logic [1:0] k;
        word_t      sum;
        word_t      exp;
        sum = word_t'(idx) + word_t'(len);
        sample_link(d, k);
        check_char(d, k, `TLK_HEAD_0, 2'b00, "head 0");
        sample_link(d, k);
        check_char(d, k, `TLK_HEAD_1, 2'b00, "head 1");
        sample_link(d, k);
        check_char(d, k, {`TLK_TX_IND, last ? `TLK_FILE_END : 8'h00}, 2'b00, "file sign");
        sample_link(d, k);
        check_char(d, k, word_t'(idx), 2'b00, "frame number");
        sample_link(d, k);
        check_char(d, k, word_t'(len), 2'b00, "valid length");
        for (int i = 0; i < len / 2; i++) begin
            sample_link(d, k);
            if (q_rd == q_wr) begin
                abort_run("a payload word left the DUT with no DMA data left in the model");
            end else begin
                exp  = model_q[q_rd];
                q_rd = q_rd + 10'd1;
                sum  = sum + exp;
                check_char(d, k, exp, 2'b00, "payload word");
            end
        end
        sample_link(d, k);
        check_char(d, k, sum, 2'b00, "checksum");
        sample_link(d, k);
        check_char(d, k, EOF_WORD, 2'b11, "eof");
    endtask

    task check_end_of_transfer(input int intr_width);
        word_t      d;
        logic [1:0] k;
        int         n;
        int         width;
        n = 0;
        sample_link(d, k);
        while (o_tx_interrupt == 1'b0) begin
            check_char(d, k, SYNC_WORD, 2'b01, "gap after last frame");
            n++;
            sample_link(d, k);
        end
        check_count(n, `TLK_GAP_WORDS, "gap length before interrupt");
        width = 0;
        while (o_tx_interrupt == 1'b1) begin
            check_char(d, k, SYNC_WORD, 2'b01, "sync during interrupt");
            width++;
            sample_link(d, k);
        end
        check_count(width, intr_width, "interrupt width");
        check_char(d, k, SYNC_WORD, 2'b01, "idle after interrupt");
        // no new frame without a new start
        check_idle(40);
    endtask

    task soft_reset_cycle;
        dma_on = 1'b0;
        repeat (2) @(posedge clk);
        i_soft_reset <= 1'b1;
        repeat (3) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(posedge clk);
        // FIFO is flushed, so is the model
        q_rd = q_wr;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one test line
    ////////////////////////////////////////////////////////////////////////////
    task run_test(input int idx);
        logic       loop_bit;
        logic       pre_bit;
        apb_data_t  ctrl;
        word_t      d;
        logic [1:0] k;
        loop_bit = idx[0];
        pre_bit  = idx[1];
        ctrl     = {29'd0, pre_bit, loop_bit, 1'b0};
        apb_write(`TLK_REG_BODY_LEN, apb_data_t'(t_body[idx]));
        apb_write(`TLK_REG_TAIL_LEN, apb_data_t'(t_tail[idx]));
        apb_write(`TLK_REG_BODY_NUM, apb_data_t'(t_num[idx]));
        apb_write(`TLK_REG_INTR_WIDTH, apb_data_t'(t_intr[idx]));
        apb_read_check(`TLK_REG_BODY_LEN, apb_data_t'(t_body[idx]), "body length");
        apb_read_check(`TLK_REG_TAIL_LEN, apb_data_t'(t_tail[idx]), "tail length");
        apb_read_check(`TLK_REG_BODY_NUM, apb_data_t'(t_num[idx]), "body count");
        apb_read_check(`TLK_REG_INTR_WIDTH, apb_data_t'(t_intr[idx]), "interrupt width");
        apb_write(`TLK_REG_CTRL, ctrl);
        apb_read_check(`TLK_REG_CTRL, ctrl, "ctrl");
        @(negedge clk);
        check_bit(o_loopen, loop_bit, "loopen pin");
        check_bit(o_pre, pre_bit, "pre pin");
        apb_write(`TLK_REG_CTRL, ctrl | 32'h1);
        if (t_rst[idx] != 0) begin
            // cut the first frame short
            wait_for_sof(`TLK_SYNC_WORDS);
            sample_link(d, k);
            check_char(d, k, `TLK_HEAD_0, 2'b00, "head 0");
            sample_link(d, k);
            check_char(d, k, `TLK_HEAD_1, 2'b00, "head 1");
            soft_reset_cycle();
            check_idle(20);
            apb_read_check(`TLK_REG_CTRL, 32'h0, "ctrl after soft reset");
            apb_read_check(`TLK_REG_BODY_LEN, 32'h0, "body length after soft reset");
            apb_read_check(`TLK_REG_TAIL_LEN, 32'h0, "tail length after soft reset");
            apb_read_check(`TLK_REG_BODY_NUM, 32'h0, "body count after soft reset");
            apb_read_check(`TLK_REG_INTR_WIDTH, 32'h0, "interrupt width after soft reset");
            apb_read_check(`TLK_REG_STATUS, 32'h10, "status after soft reset");
            @(negedge clk);
            dma_on = 1'b1;
        end else begin
            for (int f = 0; f <= t_num[idx]; f++) begin
                wait_for_sof((f == 0) ? `TLK_SYNC_WORDS : `TLK_GAP_WORDS);
                check_frame(f, (f == t_num[idx]) ? t_tail[idx] : t_body[idx], f == t_num[idx]);
            end
            check_end_of_transfer(t_intr[idx]);
        end
    endtask

    task load_vectors;
        int    fd;
        int    code;
        int    n_read;
        string line;
        int    b;
        int    t;
        int    nb;
        int    iw;
        int    rf;
        n_tests = 0;
        fd = $fopen("tests/tlk_tx_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/tlk_tx_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                n_read = $sscanf(line, "%d %d %d %d %d", b, t, nb, iw, rf);
                if (n_read == 5 && n_tests < MAX_TESTS) begin
                    t_body[n_tests] = b;
                    t_tail[n_tests] = t;
                    t_num[n_tests]  = nb;
                    t_intr[n_tests] = iw;
                    t_rst[n_tests]  = rf;
                    n_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // processes
    ////////////////////////////////////////////////////////////////////////////
    // DMA source, random beats with random gaps
    initial begin : dma_source
        beat_t beat;
        logic  taken;
        i_dma_valid <= 1'b0;
        i_dma_data  <= '0;
        beat = '0;
        q_wr = '0;
        forever begin
            @(negedge clk);
            taken = i_dma_valid & o_dma_ready & ~i_soft_reset;
            @(posedge clk);
            if (taken) begin
                model_q[q_wr]         = beat[15:0];
                model_q[q_wr + 10'd1] = beat[31:16];
                model_q[q_wr + 10'd2] = beat[47:32];
                model_q[q_wr + 10'd3] = beat[63:48];
                q_wr = q_wr + 10'd4;
            end
            if (taken || !i_dma_valid || !dma_on) begin
                if (dma_on && (($random(seed) & 3) != 0)) begin
                    beat = {$random(seed), $random(seed)};
                    i_dma_data  <= beat;
                    i_dma_valid <= 1'b1;
                end else begin
                    i_dma_valid <= 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        abort_run("the run timed out before all tests finished");
    end

    initial begin : main_flow
        apb_data_t rd;
        logic      err;
        longint    limit;
        clk      = 1'b0;
        dma_on   = 1'b0;
        limit_ns = 0;
        q_rd     = '0;
        i_soft_reset <= 1'b1;
        i_psel       <= 1'b0;
        i_penable    <= 1'b0;
        i_pwrite     <= 1'b0;
        i_paddr      <= '0;
        i_pwdata     <= '0;
        load_vectors();
        if (n_tests == 0) begin
            abort_run("no test lines found in tests/tlk_tx_vectors.txt");
        end
        // budget from the frame lengths of all tests
        limit = 64'd2000;
        for (int i = 0; i < n_tests; i++) begin
            limit = limit + longint'(t_num[i] * (t_body[i] / 2 + `TLK_GAP_WORDS + 20));
            limit = limit + longint'(t_tail[i] / 2 + `TLK_GAP_WORDS + 20 + t_intr[i] + 300);
        end
        limit_ns = limit * 40;
        repeat (3) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(posedge clk);
        apb_read_check(`TLK_REG_STATUS, 32'h10, "status after reset");
        apb_access(8'h20, 1'b0, '0, rd, err);
        check_bit(err, 1'b1, "pslverr on unmapped address");
        apb_access(`TLK_REG_STATUS, 1'b1, 32'h1, rd, err);
        check_bit(err, 1'b1, "pslverr on status write");
        check_idle(20);
        @(negedge clk);
        dma_on = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- tests/tlk_tx_vectors.txt
# body_len tail_len body_num intr_width soft_reset, all decimal
# lengths in bytes, body_num+1 frames per test, soft_reset 1 cuts the first frame
32 16 2 4 0
64 8 0 1 0
20 0 1 3 0
100 30 3 6 0
48 48 1 2 1
16 7 2 5 0
24 12 1 3 0

//--- filelist.f
+incdir+common
common/tlk_tx_pkg.sv
tx_framer/tlk_tx_fifo.sv
tx_framer/tlk_tx_framer.sv
source/tlk_tx_regs.sv
source/tlk_tx_top.sv
tests/tb_tlk_tx.sv

//--- run.sh
#!/bin/sh
# builds the TLK2711 transmit regression with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -f filelist.f --top-module tb_tlk_tx || exit 1
out=$(./obj_dir/Vtb_tlk_tx 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1
